// File: project.f
design/cgra_pkg.sv
design/pe_config_buffer.sv
design/pe_reg_file.sv
design/pe_crossbar.sv
design/pe_alu.sv
design/pe.sv
design/cgra_array.sv
tests/cgra_array_tb.sv

// File: Bender.yml
package:
  name: cgra_array

sources:
  - design/cgra_pkg.sv
  - design/pe_config_buffer.sv
  - design/pe_reg_file.sv
  - design/pe_crossbar.sv
  - design/pe_alu.sv
  - design/pe.sv
  - design/cgra_array.sv
  - target: test
    files:
      - tests/cgra_array_tb.sv

// File: tests/cgra_array_tb.sv
`timescale 1ns/10ps

module cgra_array_tb;
    import cgra_pkg::*;

    logic       clk;
    logic       rst;
    logic       config_valid;
    pe_index_t  config_pe;
    pe_inst_t   config_inst;
    logic       run;
    word_grid_t din_n;
    word_grid_t din_w;
    word_grid_t dout_s;
    word_grid_t dout_e;

    // reference model, PEs in row-major order
    pe_inst_t   m_buf [pe_count][buffer_depth];
    int         m_wp [pe_count];
    int         m_rp [pe_count];
    pe_inst_t   m_inst [pe_count];
    word_t      m_regs [pe_count][4];
    word_t      m_res [pe_count];
    word_t      m_in0 [pe_count];
    word_t      m_in1 [pe_count];
    word_t      m_alu [pe_count];
    word_t      m_out_s [pe_count];
    word_t      m_out_e [pe_count];
    word_grid_t exp_s;
    word_grid_t exp_e;

    logic [31:0] rng_state;
    logic        ran;          // run seen at least once
    int          route_mode;   // 1 west pass, 2 swapped north pass
    logic        acc_on;
    word_t       acc_base;
    word_t       acc_expect;
    pe_inst_t    prog [$];

    cgra_array cgra_array_inst (
        .clk          (clk),
        .rst          (rst),
        .config_valid (config_valid),
        .config_pe    (config_pe),
        .config_inst  (config_inst),
        .run          (run),
        .din_n        (din_n),
        .din_w        (din_w),
        .dout_s       (dout_s),
        .dout_e       (dout_e)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic word_t next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // opcode table
    function automatic word_t alu_ref(input logic [3:0] op, input word_t a, input word_t b);
        logic [63:0] prod;
        prod = {32'b0, a} * {32'b0, b};
        case (op)
            4'd1: return a + b;
            4'd2: return a - b;
            4'd3: return a & b;
            4'd4: return a | b;
            4'd5: return a ^ b;
            4'd6: return prod[31:0];
            4'd7: return a << b[4:0];
            4'd8: return a >> b[4:0];
            4'd9: return a;
            default: return '0;
        endcase
    endfunction

    function automatic word_t source_ref(input int p, input logic [2:0] sel);
        case (sel)
            3'd0: return '0;
            3'd1: return m_in0[p];
            3'd2: return m_in1[p];
            3'd7: return m_res[p];
            default: return m_regs[p][sel - 3];
        endcase
    endfunction

    function automatic pe_inst_t make_inst(input logic [3:0] op, input src_sel_t a,
                                           input src_sel_t b, input src_sel_t s,
                                           input src_sel_t e, input logic swap,
                                           input logic [3:0] mask);
        pe_inst_t inst;
        inst.opcode  = alu_op_t'(op);
        inst.sel_a   = a;
        inst.sel_b   = b;
        inst.sel_s   = s;
        inst.sel_e   = e;
        inst.swap    = swap;
        inst.wr_mask = mask;
        return inst;
    endfunction

    // outputs settle from north-west to south-east
    task automatic eval_model();
        word_t north;
        word_t west;
        int    p;
        for (int r = 0; r < grid_rows; r++) begin
            for (int c = 0; c < grid_cols; c++) begin
                p     = r * grid_cols + c;
                north = (r == 0) ? din_n[c] : m_out_s[p - grid_cols];
                west  = (c == 0) ? din_w[r] : m_out_e[p - 1];
                m_in0[p]   = m_inst[p].swap ? west : north;
                m_in1[p]   = m_inst[p].swap ? north : west;
                m_alu[p]   = alu_ref(m_inst[p].opcode, source_ref(p, m_inst[p].sel_a),
                                     source_ref(p, m_inst[p].sel_b));
                m_out_s[p] = source_ref(p, m_inst[p].sel_s);
                m_out_e[p] = source_ref(p, m_inst[p].sel_e);
            end
        end
        for (int c = 0; c < grid_cols; c++) begin
            exp_s[c] = m_out_s[(grid_rows - 1) * grid_cols + c];
        end
        for (int r = 0; r < grid_rows; r++) begin
            exp_e[r] = m_out_e[r * grid_cols + grid_cols - 1];
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            for (int p = 0; p < pe_count; p++) begin
                m_wp[p]   = 0;
                m_rp[p]   = 0;
                m_inst[p] = '0;
                m_res[p]  = '0;
                for (int i = 0; i < buffer_depth; i++) begin
                    m_buf[p][i] = '0;
                end
                for (int i = 0; i < 4; i++) begin
                    m_regs[p][i] = '0;
                end
            end
        end else begin
            for (int p = 0; p < pe_count; p++) begin
                if (config_valid && config_pe == p) begin
                    m_buf[p][m_wp[p]] = config_inst;
                    m_wp[p] = (m_wp[p] + 1) % buffer_depth;
                end
                for (int i = 0; i < 4; i++) begin
                    if (m_inst[p].wr_mask[i]) begin
                        m_regs[p][i] = (i == 0) ? m_in0[p] : (i == 1) ? m_in1[p] : m_alu[p];
                    end
                end
                m_res[p] = m_alu[p];
                if (run) begin
                    m_inst[p] = m_buf[p][m_rp[p]];
                    m_rp[p]   = (m_rp[p] + 1) % buffer_depth;
                end
            end
        end
    end

    // inputs move at +1 ns, so +2 ns sees the whole cycle
    initial begin
        forever begin
            @(posedge clk);
            #2;
            eval_model();
        end
    end

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] expected);
        $display("FAIL %s got 0x%h expected 0x%h at %0t", name, got, expected, $time);
        $display("Simulation failed");
        $fatal(1, "mismatch on %s", name);
    endtask

    model_south: assert property (@(posedge clk) disable iff (rst) dout_s == exp_s)
        else report_mismatch("dout_s", $sampled(dout_s), $sampled(exp_s));
    model_east: assert property (@(posedge clk) disable iff (rst) dout_e == exp_e)
        else report_mismatch("dout_e", $sampled(dout_e), $sampled(exp_e));
    idle_quiet: assert property (@(posedge clk) disable iff (rst) !ran |-> (dout_s | dout_e) == '0)
        else report_mismatch("dout_s/dout_e", $sampled(dout_s | dout_e), '0);
    route_west: assert property (@(posedge clk) disable iff (rst)
        route_mode == 1 |-> dout_e == din_w)
        else report_mismatch("dout_e", $sampled(dout_e), $sampled(din_w));
    route_north: assert property (@(posedge clk) disable iff (rst)
        route_mode == 2 |-> dout_e == {din_n[0], din_n[1]})
        else report_mismatch("dout_e", $sampled(dout_e), $sampled({din_n[0], din_n[1]}));
    acc_total: assert property (@(posedge clk) disable iff (rst) acc_on |-> dout_e[0] == acc_expect)
        else report_mismatch("dout_e[0]", $sampled(dout_e[0]), $sampled(acc_expect));

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            din_n = {next_random(), next_random()};
            din_w = {next_random(), next_random()};
            tick();
        end
    endtask

    task automatic apply_reset();
        run = 1'b0;
        rst = 1'b1;
        repeat (8) tick();
        rst = 1'b0;
    endtask

    task automatic write_word(input int idx, input pe_inst_t inst);
        config_valid = 1'b1;
        config_pe    = pe_index_t'(idx);
        config_inst  = inst;
        tick();
        config_valid = 1'b0;
    endtask

    task automatic program_pe(input int idx, input pe_inst_t words [$]);
        foreach (words[i]) begin
            write_word(idx, words[i]);
        end
    endtask

    task automatic fill_pe(input int idx, input pe_inst_t inst);
        repeat (buffer_depth) write_word(idx, inst);
    endtask

    task automatic load_random(input int idx, input int count);
        word_t r;
        prog.delete();
        repeat (count) begin
            r = next_random();
            prog.push_back(pe_inst_t'(r[20:0]));
        end
        program_pe(idx, prog);
    endtask

    task automatic run_cycles(input int n);
        run = 1'b1;
        ran = 1'b1;
        repeat (n) tick();
        run = 1'b0;
    endtask

    // one step per instruction, then a random stretch with run low
    task automatic exercise(input int steps, input int gap_max);
        int gap;
        for (int i = 0; i < steps; i++) begin
            din_n = {next_random(), next_random()};
            din_w = {next_random(), next_random()};
            run_cycles(1);
            gap = next_random() % (gap_max + 1);
            idle_cycles(gap + 1);
        end
    endtask

    task automatic wait_for_east(input int row, input word_t value, input int limit);
        for (int i = 0; i < limit; i++) begin
            if (dout_e[row] == value) begin
                return;
            end
            tick();
        end
        $display("timeout waiting for dout_e[%0d] to reach 0x%h", row, value);
        $display("Simulation failed");
        $fatal(1, "wait timeout");
    endtask

    initial begin
        rst          = 1'b1;
        config_valid = 1'b0;
        config_pe    = '0;
        config_inst  = '0;
        run          = 1'b0;
        din_n        = '0;
        din_w        = '0;
        exp_s        = '0;
        exp_e        = '0;
        rng_state    = 32'd64100;
        ran          = 1'b0;
        route_mode   = 0;
        acc_on       = 1'b0;
        acc_base     = '0;
        acc_expect   = '0;
        apply_reset();
        idle_cycles(10);   // nothing programmed yet

        for (int p = 0; p < pe_count; p++) begin
            fill_pe(p, make_inst(op_zero, src_zero, src_zero, src_zero, src_in1, 1'b0, 4'b0));
        end
        run_cycles(1);
        route_mode = 1;
        idle_cycles(12);
        route_mode = 0;
        apply_reset();
        for (int p = 0; p < pe_count; p++) begin
            fill_pe(p, make_inst(op_zero, src_zero, src_zero, src_in0, src_in1, 1'b1, 4'b0));
        end
        run_cycles(1);
        route_mode = 2;
        idle_cycles(12);
        route_mode = 0;

        // PE00 computes, PE01 and PE11 carry result down to dout_s[1]
        for (int pass = 0; pass < 2; pass++) begin
            apply_reset();
            prog.delete();
            for (int k = 0; k < buffer_depth; k++) begin
                prog.push_back(make_inst(4'((pass * 8 + k + 1) % 16), src_in0, src_in1,
                                         src_zero, src_result, 1'b0, 4'b0));
            end
            program_pe(0, prog);
            fill_pe(1, make_inst(op_zero, src_zero, src_zero, src_in1, src_zero, 1'b0, 4'b0));
            fill_pe(3, make_inst(op_zero, src_zero, src_zero, src_in0, src_zero, 1'b0, 4'b0));
            exercise(8, 2);
        end

        // capture once, then add reg0 into reg2 every cycle
        apply_reset();
        acc_base = next_random() | 32'd1;
        din_n[0] = acc_base;
        prog.delete();
        prog.push_back(make_inst(op_zero, src_zero, src_zero, src_zero, src_zero, 1'b0, 4'b0001));
        repeat (5) begin
            prog.push_back(make_inst(op_add, src_reg0, src_reg2, src_zero, src_reg2, 1'b0,
                                     4'b0100));
        end
        program_pe(0, prog);
        fill_pe(1, make_inst(op_zero, src_zero, src_zero, src_zero, src_in1, 1'b0, 4'b0));
        run_cycles(6);
        acc_on = 1'b1;
        for (int n = 4; n < 10; n++) begin
            acc_expect = acc_base * n;
            tick();
        end
        acc_on = 1'b0;
        wait_for_east(0, acc_base * 12, 10);

        // nine steps wrap back to entry 0
        apply_reset();
        prog.delete();
        for (int k = 0; k < buffer_depth; k++) begin
            prog.push_back(make_inst(4'(k + 1), src_in0, src_in1, src_sel_t'(k), src_result,
                                     k[0], 4'b0));
        end
        program_pe(0, prog);
        fill_pe(1, make_inst(op_zero, src_zero, src_zero, src_zero, src_in1, 1'b0, 4'b0));
        fill_pe(2, make_inst(op_zero, src_zero, src_zero, src_in0, src_zero, 1'b0, 4'b0));
        exercise(9, 3);

        // reprogram single PEs while the others keep running
        apply_reset();
        for (int p = 0; p < pe_count; p++) begin
            load_random(p, buffer_depth);
        end
        exercise(10, 2);
        load_random(2, buffer_depth);
        exercise(10, 2);
        load_random(1, 3);
        exercise(12, 2);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: design/cgra_array.sv
`timescale 1ns/10ps

module cgra_array (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 config_valid,
    input  cgra_pkg::pe_index_t  config_pe,
    input  cgra_pkg::pe_inst_t   config_inst,
    input  logic                 run,
    input  cgra_pkg::word_grid_t din_n,
    input  cgra_pkg::word_grid_t din_w,
    output cgra_pkg::word_grid_t dout_s,
    output cgra_pkg::word_grid_t dout_e
);
    import cgra_pkg::*;

    // south_bus[r] enters row r from above, east_bus[r][c] enters column c from the left
    word_grid_t south_bus [grid_rows+1];
    word_t      east_bus  [grid_rows][grid_cols+1];
    logic       pe_init   [pe_count];

    assign south_bus[0] = din_n;
    assign dout_s       = south_bus[grid_rows];

    generate
        for (genvar r = 0; r < grid_rows; r++) begin : g_row_edge
            assign east_bus[r][0] = din_w[r];
            assign dout_e[r]      = east_bus[r][grid_cols];
        end
    endgenerate

    generate
        for (genvar r = 0; r < grid_rows; r++) begin : g_row
            for (genvar c = 0; c < grid_cols; c++) begin : g_col
                localparam pe_index_t idx = pe_index_t'(r * grid_cols + c);

                // one-hot write decode
                assign pe_init[idx] = config_valid && (config_pe == idx);

                pe pe_inst (
                    .clk         (clk),
                    .rst         (rst),
                    .init        (pe_init[idx]),
                    .run         (run),
                    .config_inst (config_inst),
                    .in_n        (south_bus[r][c]),
                    .in_w        (east_bus[r][c]),
                    .out_s       (south_bus[r+1][c]),
                    .out_e       (east_bus[r][c+1])
                );
            end
        end
    endgenerate

    // an unknown address would leave the write undelivered
    config_addr_known: assert property (
        @(posedge clk) disable iff (rst) config_valid |-> !$isunknown(config_pe)
    ) else $error("cgra_array: config write with unknown PE index");

endmodule

// File: design/pe.sv
`timescale 1ns/10ps

module pe (
    input  logic               clk,
    input  logic               rst,
    input  logic               init,
    input  logic               run,
    input  cgra_pkg::pe_inst_t config_inst,
    input  cgra_pkg::word_t    in_n,
    input  cgra_pkg::word_t    in_w,
    output cgra_pkg::word_t    out_s,
    output cgra_pkg::word_t    out_e
);
    import cgra_pkg::*;

    pe_inst_t inst;
    word_t    in0;
    word_t    in1;
    word_t    reg0;
    word_t    reg1;
    word_t    reg2;
    word_t    reg3;
    word_t    operand_a;
    word_t    operand_b;
    word_t    alu_out;
    word_t    result;

    pe_config_buffer config_buffer_inst (
        .clk         (clk),
        .rst         (rst),
        .init        (init),
        .run         (run),
        .config_inst (config_inst),
        .inst        (inst)
    );

    // swap exchanges north and west
    assign in0 = inst.swap ? in_w : in_n;
    assign in1 = inst.swap ? in_n : in_w;

    pe_reg_file reg_file_inst (
        .clk     (clk),
        .rst     (rst),
        .wr_mask (inst.wr_mask),
        .in0     (in0),
        .in1     (in1),
        .alu_out (alu_out),
        .reg0    (reg0),
        .reg1    (reg1),
        .reg2    (reg2),
        .reg3    (reg3)
    );

    pe_crossbar crossbar_inst (
        .in0       (in0),
        .in1       (in1),
        .reg0      (reg0),
        .reg1      (reg1),
        .reg2      (reg2),
        .reg3      (reg3),
        .result    (result),
        .sel_a     (inst.sel_a),
        .sel_b     (inst.sel_b),
        .sel_s     (inst.sel_s),
        .sel_e     (inst.sel_e),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .out_s     (out_s),
        .out_e     (out_e)
    );

    pe_alu alu_inst (
        .a       (operand_a),
        .b       (operand_b),
        .opcode  (inst.opcode),
        .alu_out (alu_out)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
        end else begin
            result <= alu_out;   // every cycle, no enable
        end
    end

endmodule

// File: design/pe_alu.sv
`timescale 1ns/10ps

module pe_alu (
    input  cgra_pkg::word_t   a,
    input  cgra_pkg::word_t   b,
    input  cgra_pkg::alu_op_t opcode,
    output cgra_pkg::word_t   alu_out
);
    import cgra_pkg::*;

    shamt_t shamt;
    word_t  product;

    assign shamt   = b[4:0];
    assign product = a * b;   // low half only

    always_comb begin
        case (opcode)
            op_add: begin
                alu_out = a + b;
            end
            op_sub: begin
                alu_out = a - b;
            end
            op_and: begin
                alu_out = a & b;
            end
            op_or: begin
                alu_out = a | b;
            end
            op_xor: begin
                alu_out = a ^ b;
            end
            op_mul: begin
                alu_out = product;
            end
            op_shl: begin
                alu_out = a << shamt;
            end
            op_shr: begin
                alu_out = a >> shamt;   // logical
            end
            op_pass_a: begin
                alu_out = a;
            end
            default: begin
                alu_out = '0;   // op_zero and unused codes
            end
        endcase
    end

endmodule

// File: design/pe_crossbar.sv
`timescale 1ns/10ps

module pe_crossbar (
    input  cgra_pkg::word_t    in0,
    input  cgra_pkg::word_t    in1,
    input  cgra_pkg::word_t    reg0,
    input  cgra_pkg::word_t    reg1,
    input  cgra_pkg::word_t    reg2,
    input  cgra_pkg::word_t    reg3,
    input  cgra_pkg::word_t    result,
    input  cgra_pkg::src_sel_t sel_a,
    input  cgra_pkg::src_sel_t sel_b,
    input  cgra_pkg::src_sel_t sel_s,
    input  cgra_pkg::src_sel_t sel_e,
    output cgra_pkg::word_t    operand_a,
    output cgra_pkg::word_t    operand_b,
    output cgra_pkg::word_t    out_s,
    output cgra_pkg::word_t    out_e
);
    import cgra_pkg::*;

    function automatic word_t pick(input src_sel_t sel, input word_t i0, input word_t i1,
                                   input word_t r0, input word_t r1, input word_t r2,
                                   input word_t r3, input word_t res);
        word_t val;
        case (sel)
            src_in0:    val = i0;
            src_in1:    val = i1;
            src_reg0:   val = r0;
            src_reg1:   val = r1;
            src_reg2:   val = r2;
            src_reg3:   val = r3;
            src_result: val = res;
            default:    val = '0;   // src_zero
        endcase
        return val;
    endfunction

    always_comb begin
        operand_a = pick(sel_a, in0, in1, reg0, reg1, reg2, reg3, result);
        operand_b = pick(sel_b, in0, in1, reg0, reg1, reg2, reg3, result);
        out_s     = pick(sel_s, in0, in1, reg0, reg1, reg2, reg3, result);
        out_e     = pick(sel_e, in0, in1, reg0, reg1, reg2, reg3, result);
    end

    // a select outside the enum would silently route zero
    always_comb begin
        sel_known: assert (!$isunknown({sel_a, sel_b, sel_s, sel_e}))
            else $error("pe_crossbar: undefined source select");
    end

endmodule

// File: design/pe_reg_file.sv
`timescale 1ns/10ps

module pe_reg_file (
    input  logic            clk,
    input  logic            rst,
    input  logic [3:0]      wr_mask,
    input  cgra_pkg::word_t in0,
    input  cgra_pkg::word_t in1,
    input  cgra_pkg::word_t alu_out,
    output cgra_pkg::word_t reg0,
    output cgra_pkg::word_t reg1,
    output cgra_pkg::word_t reg2,
    output cgra_pkg::word_t reg3
);
    import cgra_pkg::*;

    word_t regs [reg_count];
    word_t wr_data [reg_count];

    // reg0/reg1 capture inputs, reg2/reg3 accumulate
    assign wr_data[0] = in0;
    assign wr_data[1] = in1;
    assign wr_data[2] = alu_out;
    assign wr_data[3] = alu_out;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < reg_count; i++) begin
                if (wr_mask[i]) begin
                    regs[i] <= wr_data[i];
                end
            end
        end
    end

    assign reg0 = regs[0];
    assign reg1 = regs[1];
    assign reg2 = regs[2];
    assign reg3 = regs[3];

endmodule

// File: design/pe_config_buffer.sv
`timescale 1ns/10ps

module pe_config_buffer (
    input  logic              clk,
    input  logic              rst,
    input  logic              init,
    input  logic              run,
    input  cgra_pkg::pe_inst_t config_inst,
    output cgra_pkg::pe_inst_t inst
);
    import cgra_pkg::*;

    pe_inst_t  entries [buffer_depth];
    buf_addr_t wr_ptr;
    buf_addr_t rd_ptr;
    pe_inst_t  inst_q;

    // program store, wiped on reset so nothing stale runs
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < buffer_depth; i++) begin
                entries[i] <= '0;
            end
        end else if (init) begin
            entries[wr_ptr] <= config_inst;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (init) begin
            wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
        end
    end

    // one entry per run cycle, holds otherwise
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            inst_q <= '0;
        end else if (run) begin
            rd_ptr <= rd_ptr + 1'b1;
            inst_q <= entries[rd_ptr];
        end
    end

    assign inst = inst_q;

    // top level must keep loading and stepping apart
    init_run_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(init && run)
    ) else $error("pe_config_buffer: init and run high in the same cycle");

endmodule

// File: design/cgra_pkg.sv
package cgra_pkg;

    localparam int word_width   = 32;
    localparam int grid_rows    = 2;
    localparam int grid_cols    = 2;
    localparam int pe_count     = grid_rows * grid_cols;
    localparam int buffer_depth = 8;
    localparam int reg_count    = 4;

    typedef logic [word_width-1:0]           word_t;
    typedef logic [$clog2(pe_count)-1:0]     pe_index_t;    // row * grid_cols + col
    typedef logic [$clog2(buffer_depth)-1:0] buf_addr_t;
    typedef logic [reg_count-1:0]            reg_mask_t;
    typedef logic [4:0]                      shamt_t;

    // edge buses of the grid
    typedef word_t [grid_cols-1:0] word_grid_t;

    // crossbar sources
    typedef enum logic [2:0] {
        src_zero   = 3'd0,
        src_in0    = 3'd1,
        src_in1    = 3'd2,
        src_reg0   = 3'd3,
        src_reg1   = 3'd4,
        src_reg2   = 3'd5,
        src_reg3   = 3'd6,
        src_result = 3'd7
    } src_sel_t;

    typedef enum logic [3:0] {
        op_zero   = 4'd0,
        op_add    = 4'd1,
        op_sub    = 4'd2,
        op_and    = 4'd3,
        op_or     = 4'd4,
        op_xor    = 4'd5,
        op_mul    = 4'd6,
        op_shl    = 4'd7,
        op_shr    = 4'd8,
        op_pass_a = 4'd9
    } alu_op_t;   // 10..15 give zero

    // 21 bits, all zero is an idle instruction
    typedef struct packed {
        alu_op_t   opcode;
        src_sel_t  sel_a;
        src_sel_t  sel_b;
        src_sel_t  sel_s;
        src_sel_t  sel_e;
        logic      swap;
        reg_mask_t wr_mask;
    } pe_inst_t;

endpackage
